/* rtl/wino_num_pkg.sv */
`default_nettype none

package wino_num_pkg;

	// Datapath widths
	localparam int PROD_W     = 30; // Products and all sums, wraps mod 2^30
	localparam int OUT_W      = 16;
	localparam int FRAC_SHIFT = 8;  // Low bits dropped by the quantizer

	// Tile geometry
	localparam int TILE_IN  = 6;
	localparam int TILE_OUT = 4;

	localparam int SUM_LAT = 3; // Register levels in the six-input adder

	localparam int ROW_CNT_W = $clog2(TILE_IN);
	localparam int COL_IDX_W = $clog2(TILE_OUT);

	// Power-of-two weights of m3 and m4 in transform rows 1 to 3
	localparam int SH_X2 = 1;
	localparam int SH_X4 = 2;
	localparam int SH_X8 = 3;

endpackage

`default_nettype wire

/* rtl/wino_tile_pkg.sv */
`default_nettype none

package wino_tile_pkg;
	import wino_num_pkg::*;

	typedef logic signed [PROD_W-1:0] word_t;

	typedef struct packed {
		word_t [TILE_IN-1:0] m; // m[0] is the first product of the row
	} prod_row_t;

	typedef struct packed {
		word_t [TILE_IN-1:0] m;
	} inter_col_t;

	typedef struct packed {
		word_t [TILE_OUT-1:0] y;
	} ysum_beat_t;

	typedef struct packed {
		logic [TILE_OUT-1:0][OUT_W-1:0] q;
	} y_beat_t;

	// Scaled and negated adder operands for transform row r
	function automatic inter_col_t wino_taps(input inter_col_t v, input int r);
		inter_col_t t;
		t = '0;
		t.m[1] = v.m[1]; // m1 enters every row with weight one
		case (r)
			0: begin
				t.m[0] = v.m[0];
				t.m[2] = v.m[2];
				t.m[3] = v.m[3];
				t.m[4] = v.m[4];
			end
			1: begin
				t.m[2] = -v.m[2];
				t.m[3] = v.m[3] <<< SH_X2;
				t.m[4] = -(v.m[4] <<< SH_X2);
			end
			2: begin
				t.m[2] = v.m[2];
				t.m[3] = v.m[3] <<< SH_X4;
				t.m[4] = v.m[4] <<< SH_X4;
			end
			default: begin
				t.m[2] = -v.m[2];
				t.m[3] = v.m[3] <<< SH_X8;
				t.m[4] = -(v.m[4] <<< SH_X8);
				t.m[5] = v.m[5]; // Only row 3 uses m5
			end
		endcase
		return t;
	endfunction

endpackage

`default_nettype wire

/* rtl/wino_sum6.sv */
`default_nettype none

module wino_sum6
	import wino_tile_pkg::*;
(
	input  logic       clk,
	input  inter_col_t i_a,
	output word_t      o_sum
);

	word_t lvl1 [3];
	word_t lvl2 [2];

	// Adder tree, one register per level
	always_ff @(posedge clk) begin
		lvl1[0] <= i_a.m[0] + i_a.m[1];
		lvl1[1] <= i_a.m[2] + i_a.m[3];
		lvl1[2] <= i_a.m[4] + i_a.m[5];

		lvl2[0] <= lvl1[0] + lvl1[1];
		lvl2[1] <= lvl1[2]; // Odd operand waits a level

		o_sum <= lvl2[0] + lvl2[1];
	end

endmodule

`default_nettype wire

/* rtl/wino_row_stage.sv */
`default_nettype none

module wino_row_stage
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_valid,
	input  prod_row_t  i_row,
	output logic       o_blk_valid,
	output ysum_beat_t o_blk [TILE_IN]
);

	logic [ROW_CNT_W-1:0] cnt;
	logic [SUM_LAT-1:0]   vld_sr;
	logic [SUM_LAT-1:0]   last_sr;
	logic                 last_beat;
	ysum_beat_t           sum;

	assign last_beat = i_valid && (cnt == ROW_CNT_W'(TILE_IN - 1));

	// Right-hand transform, one adder per output column
	for (genvar r = 0; r < TILE_OUT; r++) begin : g_row
		wino_sum6 u_sum (
			.clk,
			.i_a   (wino_taps(inter_col_t'(i_row), r)),
			.o_sum (sum.y[r])
		);
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt         <= '0;
			vld_sr      <= '0;
			last_sr     <= '0;
			o_blk_valid <= 1'b0;
		end else begin
			if (i_valid)
				cnt <= last_beat ? '0 : cnt + 1'b1;
			vld_sr      <= {vld_sr[SUM_LAT-2:0], i_valid};
			last_sr     <= {last_sr[SUM_LAT-2:0], last_beat};
			o_blk_valid <= last_sr[SUM_LAT-1]; // Sixth sum lands this edge
		end
	end

	// Oldest row ends up in o_blk[0]
	always_ff @(posedge clk) begin
		if (vld_sr[SUM_LAT-1]) begin
			for (int i = 0; i < TILE_IN - 1; i++)
				o_blk[i] <= o_blk[i+1];
			o_blk[TILE_IN-1] <= sum;
		end
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (!i_arst_n)
		cnt <= ROW_CNT_W'(TILE_IN - 1));

endmodule

`default_nettype wire

/* rtl/wino_col_serializer.sv */
`default_nettype none

module wino_col_serializer
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_blk_valid,
	input  ysum_beat_t i_blk [TILE_IN],
	output logic       o_col_valid,
	output inter_col_t o_col
);

	ysum_beat_t           hold [TILE_IN];
	logic [COL_IDX_W-1:0] idx;
	logic                 busy;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy <= 1'b0;
			idx  <= '0;
		end else if (i_blk_valid) begin
			busy <= 1'b1;
			idx  <= '0;
		end else if (busy) begin
			idx <= idx + 1'b1; // Wraps back to column 0
			if (idx == COL_IDX_W'(TILE_OUT - 1))
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_blk_valid)
			hold <= i_blk;
	end

	// Column idx of the held block
	always_comb begin
		for (int i = 0; i < TILE_IN; i++)
			o_col.m[i] = hold[i].y[idx];
	end

	assign o_col_valid = busy;

	// Rows of the next tile take longer than four columns
	a_no_overrun: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_blk_valid |-> !busy);

endmodule

`default_nettype wire

/* rtl/wino_col_stage.sv */
`default_nettype none

module wino_col_stage
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_col_valid,
	input  inter_col_t i_col,
	output logic       o_ysum_valid,
	output ysum_beat_t o_ysum
);

	logic [SUM_LAT-1:0] vld_sr;

	// Left-hand transform on one intermediate column
	for (genvar r = 0; r < TILE_OUT; r++) begin : g_col
		wino_sum6 u_sum (
			.clk,
			.i_a   (wino_taps(i_col, r)),
			.o_sum (o_ysum.y[r])
		);
	end

	// Valid follows the adder tree
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[SUM_LAT-2:0], i_col_valid};
	end

	assign o_ysum_valid = vld_sr[SUM_LAT-1];

endmodule

`default_nettype wire

/* rtl/wino_out_quant.sv */
`default_nettype none

module wino_out_quant
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_ysum_valid,
	input  ysum_beat_t i_ysum,
	output logic       o_valid,
	output y_beat_t    o_beat
);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_ysum_valid;
	end

	// ReLU then keep bits 23:8, upper bits simply dropped
	always_ff @(posedge clk) begin
		for (int k = 0; k < TILE_OUT; k++)
			o_beat.q[k] <= i_ysum.y[k][PROD_W-1] ? '0 : i_ysum.y[k][FRAC_SHIFT +: OUT_W];
	end

	// One tile gives four beats, tiles never abut
	a_burst_len: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(o_valid) |-> ##TILE_OUT !o_valid);

endmodule

`default_nettype wire

/* rtl/wino_inverse_top.sv */
`default_nettype none

module wino_inverse_top
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  logic      clk,
	input  logic      i_arst_n,
	input  logic      i_valid,
	input  prod_row_t i_row,
	output logic      o_valid,
	output y_beat_t   o_beat
);

	logic       blk_valid;
	ysum_beat_t blk [TILE_IN];
	logic       col_valid;
	inter_col_t col;
	logic       ysum_valid;
	ysum_beat_t ysum;

	wino_row_stage u_row_stage (
		.clk,
		.i_arst_n,
		.i_valid,
		.i_row,
		.o_blk_valid (blk_valid),
		.o_blk       (blk)
	);

	wino_col_serializer u_col_serializer (
		.clk,
		.i_arst_n,
		.i_blk_valid (blk_valid),
		.i_blk       (blk),
		.o_col_valid (col_valid),
		.o_col       (col)
	);

	wino_col_stage u_col_stage (
		.clk,
		.i_arst_n,
		.i_col_valid  (col_valid),
		.i_col        (col),
		.o_ysum_valid (ysum_valid),
		.o_ysum       (ysum)
	);

	wino_out_quant u_out_quant (
		.clk,
		.i_arst_n,
		.i_ysum_valid (ysum_valid),
		.i_ysum       (ysum),
		.o_valid,
		.o_beat
	);

endmodule

`default_nettype wire

/* dv/wino_checker.sv */
`default_nettype none

module wino_checker
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  logic    clk,
	input  int      i_cycle,
	input  logic    i_valid,
	input  y_beat_t i_beat,
	output int      o_beats_done,
	output int      o_err_count
);

	timeunit 1ns;
	timeprecision 100ps;

	y_beat_t exp_beat_q [$]; // Expected beats in output order
	int      exp_cyc_q [$];  // Cycle each expected beat is due
	int      beats_done = 0;
	int      err_count = 0;

	assign o_beats_done = beats_done;
	assign o_err_count  = err_count;

	// Outputs sampled at the edge, before the DUT updates them
	always @(posedge clk) begin
		y_beat_t want;
		int      n_err;
		n_err = 0;
		if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == i_cycle) begin
			want = exp_beat_q.pop_front();
			void'(exp_cyc_q.pop_front());
			if (i_valid !== 1'b1) begin
				$display("Output beat %0d did not arrive at %0d ns, o_valid was low",
					beats_done, $time);
				n_err = 1;
			end else begin
				for (int r = 0; r < TILE_OUT; r++) begin
					if (i_beat.q[r] !== want.q[r]) begin
						$display("Error at %0d ns: beat %0d word %0d is %h, expected %h",
							$time, beats_done, r, i_beat.q[r], want.q[r]);
						n_err++;
					end
				end
			end
			beats_done <= beats_done + 1;
		end else if (i_valid !== 1'b0) begin
			$display("Unexpected o_valid at %0d ns while no output beat was due", $time);
			n_err = 1;
		end
		err_count <= err_count + n_err;
	end

endmodule

`default_nettype wire

/* dv/wino_tb.sv */
`default_nettype none

module wino_tb
	import wino_num_pkg::*, wino_tile_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_TILES    = 3;
	localparam int TILE_WORDS = TILE_IN * TILE_IN + TILE_OUT * TILE_OUT;
	localparam int LATENCY    = 9; // Last input beat to first output beat
	localparam int WAIT_LIMIT = 100;

	logic      clk = 1'b0;
	logic      i_arst_n;
	logic      i_valid;
	prod_row_t i_row;
	logic      o_valid;
	y_beat_t   o_beat;

	logic [PROD_W-1:0] trace_mem [N_TILES * TILE_WORDS];
	logic [31:0]       lfsr = 32'hca3a;
	int                cycle = 0;
	int                beats_done;
	int                err_count;
	int                n_pass = 0;
	int                n_fail = 0;
	logic              timed_out = 1'b0;

	always #4 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	wino_inverse_top u_dut (
		.clk,
		.i_arst_n,
		.i_valid,
		.i_row,
		.o_valid,
		.o_beat
	);

	wino_checker u_checker (
		.clk,
		.i_cycle      (cycle),
		.i_valid      (o_valid),
		.i_beat       (o_beat),
		.o_beats_done (beats_done),
		.o_err_count  (err_count)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		i_valid <= 1'b0;
	endtask

	task automatic send_row(input int t, input int i);
		@(posedge clk);
		i_valid <= 1'b1;
		for (int k = 0; k < TILE_IN; k++)
			i_row.m[k] <= trace_mem[t * TILE_WORDS + i * TILE_IN + k];
	endtask

	// Expected beats follow the six rows of each tile in the trace
	task automatic expect_tile(input int t, input int first_cyc);
		y_beat_t b;
		int      base;
		base = t * TILE_WORDS + TILE_IN * TILE_IN;
		for (int j = 0; j < TILE_OUT; j++) begin
			for (int r = 0; r < TILE_OUT; r++)
				b.q[r] = trace_mem[base + j * TILE_OUT + r][OUT_W-1:0];
			u_checker.exp_beat_q.push_back(b);
			u_checker.exp_cyc_q.push_back(first_cyc + j);
		end
	endtask

	task automatic report_tiles();
		int base_err;
		int waited;
		base_err = 0;
		for (int n = 0; n < 2 * N_TILES && !timed_out; n++) begin
			waited = 0;
			while (beats_done < (n + 1) * TILE_OUT && waited < WAIT_LIMIT) begin
				@(posedge clk);
				waited++;
			end
			if (beats_done < (n + 1) * TILE_OUT) begin
				$display("Timeout: tile %0d gave no complete output within %0d cycles",
					n, WAIT_LIMIT);
				timed_out = 1'b1;
			end else if (err_count != base_err) begin
				$display("Tile %0d (trace tile %0d) failed with %0d errors",
					n, n % N_TILES, err_count - base_err);
				n_fail++;
			end else begin
				$display("Tile %0d (trace tile %0d) passed", n, n % N_TILES);
				n_pass++;
			end
			base_err = err_count;
		end
	endtask

	initial begin
		i_arst_n = 1'b1;
		i_valid  = 1'b0;
		i_row    = '0;
		$readmemh("dv/wino_trace.txt", trace_mem);
		#1 i_arst_n = 1'b0;
		repeat (5) @(posedge clk);
		i_arst_n <= 1'b1;

		fork
			begin
				int gap;
				// Pass 0 with random gaps, pass 1 back to back
				for (int p = 0; p < 2; p++) begin
					for (int t = 0; t < N_TILES; t++) begin
						if (p == 0) begin
							draw_bits(2, gap);
							repeat (gap) idle_cycle();
						end
						for (int i = 0; i < TILE_IN; i++) begin
							if (p == 0 && i != 0) begin
								draw_bits(1, gap);
								if (gap != 0)
									idle_cycle();
							end
							send_row(t, i);
						end
						expect_tile(t, cycle + 1 + LATENCY); // DUT takes the row next edge
					end
				end
				idle_cycle();
			end
			report_tiles();
		join

		repeat (8) @(posedge clk); // Stray beats after the last tile
		$display("Tiles passed: %0d, failed: %0d, checker errors: %0d",
			n_pass, n_fail, err_count);
		if (timed_out || n_fail != 0 || err_count != 0) begin
			$display("RESULT: FAIL");
		end else begin
			$display("RESULT: PASS");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/wino_trace.txt */
// Per tile: six input rows m0..m5 (30-bit hex, two's complement)
// then four output beats for columns 0..3, each q0..q3 = Y rows 0..3 (16-bit hex)
// Tile 0: all 0x1000, m[1][0] = 0x1200, m[5][5] = 0x1300
00001000 00001000 00001000 00001000 00001000 00001000
00001200 00001000 00001000 00001000 00001000 00001000
00001000 00001000 00001000 00001000 00001000 00001000
00001000 00001000 00001000 00001000 00001000 00001000
00001000 00001000 00001000 00001000 00001000 00001000
00001000 00001000 00001000 00001000 00001000 00001300
0192 0002 0322 0052
0000 0000 0000 0000
0320 0000 0640 00a0
0050 0000 00a0 0013
// Tile 1: m[2][4] = -0x1100, alternating signs so half the words clip to zero
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 3fffef00 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
0000 0011 0000 0011
0022 0000 0022 0000
0000 0044 0000 0044
0088 0000 0088 0000
// Tile 2: m[0][0] = 0x10000, m[3][3] = 0x123400, entries up to 0x48d0000
00010000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00123400 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
1334 2468 48d0 91a0
2468 48d0 91a0 2340
48d0 91a0 2340 4680
91a0 2340 4680 8d00

/* wino_inverse.f */
rtl/wino_num_pkg.sv
rtl/wino_tile_pkg.sv
rtl/wino_sum6.sv
rtl/wino_row_stage.sv
rtl/wino_col_serializer.sv
rtl/wino_col_stage.sv
rtl/wino_out_quant.sv
rtl/wino_inverse_top.sv
dv/wino_checker.sv
dv/wino_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Winograd inverse-transform testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module wino_tb -f wino_inverse.f \
	--Mdir obj_dir -o wino_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/wino_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0
